// ==== filelist.f ====
+incdir+verilog
+incdir+tb
verilog/mem_card_pkg.sv
verilog/mem_bank_if.sv
verilog/mem_sram_bank.sv
verilog/mem_bus_ctrl.sv
verilog/mem_card.sv
tb/tb_mem_card.sv

// ==== tb/mem_card_model.svh ====
`ifndef MEM_CARD_MODEL_SVH
`define MEM_CARD_MODEL_SVH

////////////////////////////////
// Reference memory model
////////////////////////////////

localparam logic [`MEM_BLK_W-1:0] ram_blk = `MEM_RAM_BLK;
localparam logic [`MEM_BLK_W-1:0] rom_blk = `MEM_ROM_BLK;
localparam int exp_latency = 2;             // Edges from acceptance to ack or err

// Words by bank index, plus which lanes hold known data
logic [`MEM_DATA_W-1:0] ram_words [int];
logic [`MEM_SEL_W-1:0]  ram_known [int];
logic [`MEM_DATA_W-1:0] rom_words [int];
logic [`MEM_SEL_W-1:0]  rom_known [int];

function automatic region_t region_of(input logic [`MEM_ADDR_W-1:0] a);
   logic [`MEM_BLK_W-1:0] blk;
   blk = a[`MEM_ADDR_W-1 -: `MEM_BLK_W];   // Top five address bits
   if (blk == ram_blk)
      return region_ram;
   else if (blk == rom_blk)
      return region_rom;
   return region_none;                      // Every other block
endfunction

// Bits above the bank width are ignored, so they mirror
function automatic int bank_index(input logic [`MEM_ADDR_W-1:0] a);
   return int'(a[`MEM_BANK_AW-1:0]);
endfunction

function automatic logic [`MEM_DATA_W-1:0] merge_word(input logic [`MEM_DATA_W-1:0] old,
                                                      input logic [`MEM_DATA_W-1:0] d,
                                                      input logic [`MEM_SEL_W-1:0]  s);
   logic [`MEM_DATA_W-1:0] w;
   w = old;
   if (s[0])
      w[7:0] = d[7:0];                      // Low lane
   if (s[1])
      w[15:8] = d[15:8];                    // High lane
   return w;
endfunction

// Expected read word and its known lanes, unmapped reads give zero
function automatic region_t exp_read(input  logic [`MEM_ADDR_W-1:0] a,
                                     output logic [`MEM_DATA_W-1:0] word,
                                     output logic [`MEM_SEL_W-1:0]  mask);
   int      idx;
   region_t r;
   idx  = bank_index(a);
   r    = region_of(a);
   word = '0;
   mask = '0;
   if (r == region_ram && ram_words.exists(idx)) begin
      word = ram_words[idx];
      mask = ram_known[idx];
   end else if (r == region_rom && rom_words.exists(idx)) begin
      word = rom_words[idx];
      mask = rom_known[idx];
   end else if (r == region_none) begin
      mask = '1;                            // dat_r must be all zero
   end
   return r;
endfunction

function automatic void update_model(input logic [`MEM_ADDR_W-1:0] a,
                                     input logic [`MEM_DATA_W-1:0] d,
                                     input logic [`MEM_SEL_W-1:0]  s,
                                     input logic                   wp_at);
   int      idx;
   region_t r;
   idx = bank_index(a);
   r   = region_of(a);
   if (r == region_ram) begin
      if (!ram_words.exists(idx)) begin
         ram_words[idx] = '0;
         ram_known[idx] = '0;
      end
      ram_words[idx] = merge_word(ram_words[idx], d, s);
      ram_known[idx] = ram_known[idx] | s;
   end else if (r == region_rom && !wp_at) begin   // Protected writes are dropped
      if (!rom_words.exists(idx)) begin
         rom_words[idx] = '0;
         rom_known[idx] = '0;
      end
      rom_words[idx] = merge_word(rom_words[idx], d, s);
      rom_known[idx] = rom_known[idx] | s;
   end
endfunction

////////////////////////////////
// Compare tasks
////////////////////////////////

task automatic report_mismatch(input string msg);
   fail_count++;
   $display("mismatch at %0t ns: %s", $time, msg);
   $display("Checks failed");
   $fatal(1, "stopping at the first error");
endtask

// Only lanes the model has seen written are compared
task automatic check_data(input logic [`MEM_DATA_W-1:0] got,
                          input logic [`MEM_DATA_W-1:0] exp,
                          input logic [`MEM_SEL_W-1:0]  mask,
                          input string                  what);
   int lane;
   for (lane = 0; lane < `MEM_SEL_W; lane++) begin
      if (mask[lane] && got[lane*8 +: 8] !== exp[lane*8 +: 8])
         report_mismatch($sformatf("%s dat_r %04h expected %04h in lanes %02b",
                                   what, got, exp, mask));
   end
endtask

task automatic check_resp(input region_t exp_region, input logic got_ack,
                          input logic got_err, input logic got_held, input string what);
   logic exp_ack;
   exp_ack = (exp_region != region_none);
   if (got_ack !== exp_ack || got_err !== !exp_ack)
      report_mismatch($sformatf("%s ack %b err %b for %s", what, got_ack, got_err,
                                exp_region.name()));
   if (got_held !== 1'b0)
      report_mismatch($sformatf("%s response held past one cycle", what));
endtask

task automatic check_latency(input int got_cycles, input string what);
   if (got_cycles != exp_latency)
      report_mismatch($sformatf("%s answered after %0d cycles, expected %0d",
                                what, got_cycles, exp_latency));
endtask

`endif

// ==== tb/tb_mem_card.sv ====
`include "mem_card_consts.svh"

`timescale 1ns/1ns

module tb_mem_card;

   import mem_card_pkg::*;

   localparam int clk_period    = 10;
   localparam int drive_delay   = 1;             // Inputs move 1 ns after the edge
   localparam int reset_cycles  = 8;
   localparam int directed_ops  = 60;            // Directed requests, rounded up
   localparam int random_ops    = 300;
   localparam int budget_cycles = (directed_ops + random_ops) * 6 + reset_cycles + 200;

   logic                   clk1;
   logic                   rst_n;
   logic                   cyc;
   logic                   stb;
   logic                   we;
   logic [`MEM_ADDR_W-1:0] adr;
   logic [`MEM_DATA_W-1:0] dat_w;
   logic [`MEM_SEL_W-1:0]  sel;
   logic                   wp;
   logic [`MEM_DATA_W-1:0] dat_r;
   logic                   ack;
   logic                   err;

   int seed;
   int checked;
   int fail_count;

   // One finished bus request as seen by the master
   typedef struct {
      logic                   wr;
      logic [`MEM_ADDR_W-1:0] adr;
      logic [`MEM_DATA_W-1:0] dat_w;
      logic [`MEM_SEL_W-1:0]  sel;
      logic                   wp;       // wp while the request ran
      logic [`MEM_DATA_W-1:0] dat_r;
      logic                   ack;
      logic                   err;
      logic                   held;     // ack or err one cycle later
      int                     cycles;   // Edges after acceptance
   } bus_txn_t;

   bus_txn_t txn_q [$];

   `include "mem_card_model.svh"

   mem_card i_dut (
      .clk1  (clk1),
      .rst_n (rst_n),
      .cyc   (cyc),
      .stb   (stb),
      .we    (we),
      .adr   (adr),
      .dat_w (dat_w),
      .sel   (sel),
      .wp    (wp),
      .dat_r (dat_r),
      .ack   (ack),
      .err   (err)
   );

   initial begin
      clk1 = 1'b0;
      forever #(clk_period / 2) clk1 = ~clk1;
   end

   ////////////////////////////////
   // Wishbone master
   ////////////////////////////////

   // Entered and left 1 ns after a rising edge
   task automatic run_request(input logic wr, input logic [`MEM_ADDR_W-1:0] a,
                              input logic [`MEM_DATA_W-1:0] d,
                              input logic [`MEM_SEL_W-1:0] s);
      bus_txn_t t;
      t.cycles = 0;
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = wr;
      adr   = a;
      dat_w = d;
      sel   = s;
      @(posedge clk1);                         // Acceptance, the slave is idle
      do begin
         @(posedge clk1);
         #drive_delay;
         t.cycles++;
      end while (ack !== 1'b1 && err !== 1'b1);
      t.wr    = wr;
      t.adr   = a;
      t.dat_w = d;
      t.sel   = s;
      t.wp    = wp;
      t.dat_r = dat_r;                         // Valid while ack is high
      t.ack   = ack;
      t.err   = err;
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
      @(posedge clk1);
      #drive_delay;
      t.held = ack | err;
      txn_q.push_back(t);
   endtask

   task automatic wb_write(input logic [`MEM_ADDR_W-1:0] a,
                           input logic [`MEM_DATA_W-1:0] d, input logic [`MEM_SEL_W-1:0] s);
      run_request(1'b1, a, d, s);
   endtask

   task automatic wb_read(input logic [`MEM_ADDR_W-1:0] a);
      run_request(1'b0, a, '0, '1);
   endtask

   ////////////////////////////////
   // Comparison
   ////////////////////////////////

   task automatic compare_txn(input bus_txn_t t);
      logic [`MEM_DATA_W-1:0] exp_word;
      logic [`MEM_SEL_W-1:0]  exp_mask;
      region_t                exp_region;
      string                  what;
      exp_region = exp_read(t.adr, exp_word, exp_mask);
      what = $sformatf("%s at %06h", t.wr ? "write" : "read", t.adr);
      check_resp(exp_region, t.ack, t.err, t.held, what);
      check_latency(t.cycles, what);
      if (t.wr) begin
         check_data(t.dat_r, '0, '1, what);      // Writes return zero
         update_model(t.adr, t.dat_w, t.sel, t.wp);
      end else begin
         check_data(t.dat_r, exp_word, exp_mask, what);
      end
      checked++;
   endtask

   initial begin : compare_proc
      bus_txn_t t;
      forever begin
         wait (txn_q.size() != 0);
         t = txn_q.pop_front();
         compare_txn(t);
      end
   end

   initial begin
      #(budget_cycles * clk_period);
      $display("Checks failed");
      $fatal(1, "simulation timed out after %0d cycles", budget_cycles);
   end

   ////////////////////////////////
   // Tests
   ////////////////////////////////

   task automatic idle_check();
      repeat (4) begin
         @(posedge clk1);
         #drive_delay;
         if (ack !== 1'b0 || err !== 1'b0)
            report_mismatch("response while stb is low");
      end
   endtask

   task automatic ram_tests();
      wb_write({ram_blk, 19'd5}, 16'h1234, 2'b11);
      wb_read({ram_blk, 19'd5});
      wb_write({ram_blk, 19'd5}, 16'hffab, 2'b01);   // Low lane only
      wb_read({ram_blk, 19'd5});
      wb_write({ram_blk, 19'd5}, 16'hcdff, 2'b10);   // High lane only
      wb_read({ram_blk, 19'd5});
      wb_read({ram_blk, 9'h1ff, 10'd5});             // Mirrors of word 5
      wb_read({ram_blk, 9'h001, 10'd5});
      wb_write({ram_blk, 9'h0a5, 10'd6}, 16'h5a5a, 2'b11);
      wb_read({ram_blk, 19'd6});
   endtask

   task automatic rom_tests();
      int i;
      wp = 1'b0;                                      // ROM open for filling
      for (i = 0; i < 8; i++)
         wb_write({rom_blk, 9'd0, 10'(i)}, 16'hbe00 + 16'(i), 2'b11);
      for (i = 0; i < 8; i++)
         wb_read({rom_blk, 9'h0c3, 10'(i)});
      wp = 1'b1;
      wb_write({rom_blk, 19'd2}, 16'h0bad, 2'b11);   // Ack but no store
      wb_write({rom_blk, 19'd3}, 16'h0bad, 2'b01);
      wb_read({rom_blk, 19'd2});
      wb_read({rom_blk, 19'd3});
   endtask

   task automatic unmapped_tests();
      logic [`MEM_BLK_W-1:0] blk;
      int                    i;
      wp = 1'b0;                                      // Even an open ROM stays intact
      for (i = 0; i < 4; i++) begin
         blk = `MEM_BLK_W'(i * 7 + 1);                // 1, 8, 15, 22
         wb_write({blk, 19'd5}, 16'hdead, 2'b11);
         wb_read({blk, 19'd5});
      end
      wb_read({ram_blk, 19'd5});
      wb_read({rom_blk, 19'd5});
   endtask

   task automatic random_traffic();
      logic [`MEM_ADDR_W-1:0] a;
      logic [`MEM_BLK_W-1:0]  blk;
      logic [`MEM_DATA_W-1:0] d;
      logic [`MEM_SEL_W-1:0]  s;
      int                     pick;
      int                     i;
      for (i = 0; i < random_ops; i++) begin
         if (i % 100 == 0)
            wp = ((i / 100) % 2 == 1);                // Open, protected, open
         pick = $unsigned($random(seed)) % 3;
         blk  = $random(seed);
         if (pick == 0)
            blk = ram_blk;
         else if (pick == 1)
            blk = rom_blk;
         else if (blk == ram_blk || blk == rom_blk)
            blk = blk + 1'b1;                         // Step off a mapped block
         a = $random(seed);
         a[`MEM_ADDR_W-1 -: `MEM_BLK_W] = blk;
         a[9:5] = '0;                                 // 32 words, mirror bits random
         d = $random(seed);
         s = $random(seed);
         if ($random(seed) & 1)
            wb_write(a, d, s);
         else
            wb_read(a);
      end
   endtask

   initial begin
      seed       = 32'h9e125951;
      checked    = 0;
      fail_count = 0;
      rst_n = 1'b0;
      cyc   = 1'b0;
      stb   = 1'b0;
      we    = 1'b0;
      adr   = '0;
      dat_w = '0;
      sel   = '0;
      wp    = 1'b1;
      repeat (reset_cycles) @(posedge clk1);
      #drive_delay rst_n = 1'b1;
      idle_check();
      ram_tests();
      rom_tests();
      unmapped_tests();
      random_traffic();
      wait (txn_q.size() == 0);
      @(posedge clk1);                                // Let the last compare finish
      if (fail_count == 0) begin
         $display("%0d requests compared", checked);
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// ==== verilog/mem_card.sv ====
`include "mem_card_consts.svh"

`timescale 1ns/1ns

module mem_card (
   input  logic                   clk1,     // First clock phase, the only clock
   input  logic                   rst_n,
   // Wishbone classic slave
   input  logic                   cyc,
   input  logic                   stb,
   input  logic                   we,
   input  logic [`MEM_ADDR_W-1:0] adr,      // 24-bit word address
   input  logic [`MEM_DATA_W-1:0] dat_w,
   input  logic [`MEM_SEL_W-1:0]  sel,
   input  logic                   wp,       // Low makes the ROM writable
   output logic [`MEM_DATA_W-1:0] dat_r,
   output logic                   ack,
   output logic                   err
);

   ////////////////////////////////
   // Bank links
   ////////////////////////////////

   mem_bank_if #(.AW(`MEM_BANK_AW)) ram_bus ();   // Block 0
   mem_bank_if #(.AW(`MEM_BANK_AW)) rom_bus ();   // Block 16

   ////////////////////////////////
   // Bus controller
   ////////////////////////////////

   mem_bus_ctrl #(
      .BANK_AW (`MEM_BANK_AW)
   ) i_ctrl (
      .clk1    (clk1),
      .rst_n   (rst_n),
      .cyc     (cyc),
      .stb     (stb),
      .we      (we),
      .adr     (adr),
      .dat_w   (dat_w),
      .sel     (sel),
      .wp      (wp),
      .dat_r   (dat_r),
      .ack     (ack),
      .err     (err),
      .ram_bus (ram_bus),
      .rom_bus (rom_bus)
   );

   ////////////////////////////////
   // Memory banks
   ////////////////////////////////

   // RAM proper
   mem_sram_bank #(.AW(`MEM_BANK_AW)) i_ram (.clk1(clk1), .mem(ram_bus));

   // RAM standing in for the ROM, filled by writes with wp low
   mem_sram_bank #(.AW(`MEM_BANK_AW)) i_rom (.clk1(clk1), .mem(rom_bus));

endmodule

// ==== verilog/mem_bus_ctrl.sv ====
`include "mem_card_consts.svh"

`timescale 1ns/1ns

module mem_bus_ctrl #(
   parameter int BANK_AW = `MEM_BANK_AW   // Up to 19, one block's worth
) (
   input  logic                   clk1,
   input  logic                   rst_n,
   // Wishbone classic slave
   input  logic                   cyc,
   input  logic                   stb,
   input  logic                   we,
   input  logic [`MEM_ADDR_W-1:0] adr,
   input  logic [`MEM_DATA_W-1:0] dat_w,
   input  logic [`MEM_SEL_W-1:0]  sel,
   input  logic                   wp,     // ROM write protect, high = protected
   output logic [`MEM_DATA_W-1:0] dat_r,
   output logic                   ack,
   output logic                   err,
   // Banks
   mem_bank_if.ctrl               ram_bus,
   mem_bank_if.ctrl               rom_bus
);

   import mem_card_pkg::*;

   localparam logic [`MEM_BLK_W-1:0] ram_blk = `MEM_RAM_BLK;
   localparam logic [`MEM_BLK_W-1:0] rom_blk = `MEM_ROM_BLK;

   bus_state_t             state_q;      // FSM state
   region_t                region_d;     // Decode of the live address
   region_t                region_q;     // Region latched at acceptance
   logic [`MEM_BLK_W-1:0]  blk;          // ab[23:19]
   logic                   accept;       // Request taken this edge
   logic [BANK_AW-1:0]     addr_q;       // Payload, held for the access cycle
   logic [`MEM_DATA_W-1:0] wdata_q;
   logic [`MEM_SEL_W-1:0]  sel_q;
   logic                   we_q;

   ////////////////////////////////
   // Block decode
   ////////////////////////////////

   assign blk    = adr[`MEM_ADDR_W-1 -: `MEM_BLK_W];
   assign accept = (state_q == idle) && cyc && stb;

   always_comb begin
      case (blk)
         ram_blk: region_d = region_ram;
         rom_blk: region_d = region_rom;
         default: region_d = region_none;   // Unmapped, no chip select
      endcase
   end

   ////////////////////////////////
   // Request capture
   ////////////////////////////////

   // Only the low bits reach the bank, so higher ones mirror
   always_ff @(posedge clk1) begin
      if (accept) begin
         addr_q  <= adr[BANK_AW-1:0];
         wdata_q <= dat_w;
         sel_q   <= sel;
         we_q    <= we;
      end
   end

   ////////////////////////////////
   // Bus FSM
   ////////////////////////////////

   always_ff @(posedge clk1) begin
      if (!rst_n) begin
         state_q  <= idle;
         region_q <= region_none;
         ack      <= 1'b0;
         err      <= 1'b0;
      end else begin
         ack <= 1'b0;                                // Responses last one cycle
         err <= 1'b0;
         case (state_q)
            idle: begin
               if (accept) begin
                  state_q  <= access;
                  region_q <= region_d;
               end
            end
            access: state_q <= respond;              // Bank samples at this edge
            respond: begin
               state_q <= idle;                      // Master drops stb on the ack
               ack     <= (region_q != region_none);
               err     <= (region_q == region_none);  // Unmapped block
            end
            default: state_q <= idle;
         endcase
      end
   end

   ////////////////////////////////
   // Bank drive
   ////////////////////////////////

   // Strobe only during access, towards the latched region
   assign ram_bus.cs    = (state_q == access) && (region_q == region_ram);
   assign ram_bus.we    = we_q;
   assign ram_bus.addr  = addr_q;
   assign ram_bus.wdata = wdata_q;
   assign ram_bus.be    = sel_q;

   // Protected ROM writes still get ack, the bank just never sees we
   assign rom_bus.cs    = (state_q == access) && (region_q == region_rom);
   assign rom_bus.we    = we_q && !wp;
   assign rom_bus.addr  = addr_q;
   assign rom_bus.wdata = wdata_q;
   assign rom_bus.be    = sel_q;

   ////////////////////////////////
   // Read steering
   ////////////////////////////////

   // Loaded on the same edge as ack, so it lines up with the response
   always_ff @(posedge clk1) begin
      if (!rst_n) begin
         dat_r <= '0;
      end else begin
         dat_r <= '0;                                // Zero on writes and err
         if ((state_q == respond) && !we_q) begin
            case (region_q)
               region_ram: dat_r <= ram_bus.rdata;
               region_rom: dat_r <= rom_bus.rdata;
               default:    dat_r <= '0;
            endcase
         end
      end
   end

endmodule

// ==== verilog/mem_sram_bank.sv ====
`include "mem_card_consts.svh"

`timescale 1ns/1ns

// Two byte-wide SRAMs sharing an address, like the card's lo/hi pairs
module mem_sram_bank #(
   parameter int AW = `MEM_BANK_AW   // Must match the interface width
) (
   input  logic      clk1,
   mem_bank_if.bank  mem
);

   localparam int depth = 1 << AW;   // Words per lane

   ////////////////////////////////
   // Lane storage
   ////////////////////////////////

   // Contents survive reset
   logic [7:0] lo_mem [0:depth-1];   // dat[7:0]
   logic [7:0] hi_mem [0:depth-1];   // dat[15:8]

   ////////////////////////////////
   // Write port
   ////////////////////////////////

   always_ff @(posedge clk1) begin
      if (mem.cs && mem.we) begin
         if (mem.be[0])
            lo_mem[mem.addr] <= mem.wdata[7:0];
         if (mem.be[1])
            hi_mem[mem.addr] <= mem.wdata[`MEM_DATA_W-1:8];
      end
   end

   ////////////////////////////////
   // Read port
   ////////////////////////////////

   // Every strobe loads rdata, which then holds until the next one.
   // A write strobe returns the word as it was before the write.
   always_ff @(posedge clk1) begin
      if (mem.cs) begin
         mem.rdata <= {hi_mem[mem.addr], lo_mem[mem.addr]};
      end
   end

endmodule

// ==== verilog/mem_bank_if.sv ====
`include "mem_card_consts.svh"

`timescale 1ns/1ns

// Controller to one byte-lane pair
interface mem_bank_if #(
   parameter int AW = `MEM_BANK_AW   // Word address bits seen by the bank
);

   logic                   cs;       // One-cycle strobe per access
   logic                   we;       // Write when set, already wp gated
   logic [AW-1:0]          addr;     // Word address inside the bank
   logic [`MEM_DATA_W-1:0] wdata;    // Write data, both lanes
   logic [`MEM_SEL_W-1:0]  be;       // Byte enables, bit 0 is the low lane
   logic [`MEM_DATA_W-1:0] rdata;    // Registered read word

   // Bus side
   modport ctrl (
      output cs, we, addr, wdata, be,
      input  rdata
   );

   // Memory side
   modport bank (
      input  cs, we, addr, wdata, be,
      output rdata
   );

endinterface

// ==== verilog/mem_card_pkg.sv ====
package mem_card_pkg;

   ////////////////////////////////
   // Controller and decode types
   ////////////////////////////////

   // Bus controller FSM, one pass per request
   typedef enum logic [1:0] {
      idle,                     // Waiting for cyc and stb
      access,                   // Bank strobed this cycle
      respond                   // ack or err on the bus
   } bus_state_t;

   // Result of the block decode on ab[23:19]
   typedef enum logic [1:0] {
      region_ram,               // Block 0
      region_rom,               // Block 16, write protectable
      region_none               // Anything else, answered with err
   } region_t;

endpackage

// ==== verilog/mem_card_consts.svh ====
`ifndef MEM_CARD_CONSTS_SVH
`define MEM_CARD_CONSTS_SVH

////////////////////////////////
// Backplane bus widths
////////////////////////////////

`define MEM_ADDR_W 24           // Word address, ab[23:0]
`define MEM_DATA_W 16           // Two byte lanes
`define MEM_SEL_W  2            // One select per lane

////////////////////////////////
// Bank geometry and regions
////////////////////////////////

`define MEM_BANK_AW 10          // 1024 words per bank

// Block field sits in the top address bits, ab[23:19]
`define MEM_BLK_W   5
`define MEM_RAM_BLK 0           // RAM at the bottom of memory
`define MEM_ROM_BLK 16          // ROM where ab[23] is set

`endif
